// File: logic/qsys_cfg_pkg.sv
/* Sizes and counts of the packet queue system */

package qsys_cfg_pkg;

    //////////////////////////////////////////////////////////////
    // Port and queue counts

    localparam int num_egr_ports = 4;

    // Priority 1 is served before priority 0
    localparam int num_prios = 2;

    localparam int num_queues = num_egr_ports * num_prios;

    //////////////////////////////////////////////////////////////
    // Storage sizes

    // Words per queue
    localparam int queue_depth = 16;

    // Longest packet the sources may send
    localparam int max_pkt_words = 8;

    localparam int data_width = 32;

endpackage

// File: logic/qsys_types_pkg.sv
/* Vector types and the dequeue state encoding of the queue system */

package qsys_types_pkg;

    //////////////////////////////////////////////////////////////
    // Vector types

    typedef logic [qsys_cfg_pkg::data_width-1:0] data_t;

    typedef logic [$clog2(qsys_cfg_pkg::num_egr_ports)-1:0] egr_port_t;

    typedef logic [$clog2(qsys_cfg_pkg::num_prios)-1:0] prio_t;

    // Port in the upper bits, priority in the lowest bit
    typedef logic [$clog2(qsys_cfg_pkg::num_queues)-1:0] queue_id_t;

    typedef logic [$clog2(qsys_cfg_pkg::queue_depth)-1:0] q_ptr_t;

    // One extra bit, a full queue of one-word packets holds queue_depth of them
    typedef logic [$clog2(qsys_cfg_pkg::queue_depth):0] pkt_count_t;

    typedef logic [qsys_cfg_pkg::num_egr_ports-1:0] port_mask_t;

    //////////////////////////////////////////////////////////////
    // Dequeue FSM states

    typedef enum logic [1:0] {
        idle,
        pick,
        send
    } deq_state_t;

endpackage

// File: logic/queue_store.sv
/* Eight circular word queues in one shared storage array,
   with per-queue read and write pointers, fill counts and full flags */

`timescale 1ns/1ps

module queue_store (
    input  logic                                   core_clk_ifc,
    input  logic                                   rst_n,
    input  logic                                   wr_en,
    input  qsys_types_pkg::queue_id_t              wr_queue,
    input  qsys_types_pkg::data_t                  wr_data,
    input  logic                                   wr_last,
    input  logic                                   rd_en,
    input  qsys_types_pkg::queue_id_t              rd_queue,
    output qsys_types_pkg::data_t                  head_data,
    output logic                                   head_last,
    output logic [qsys_cfg_pkg::num_queues-1:0]    full
);

    localparam int store_words = qsys_cfg_pkg::num_queues * qsys_cfg_pkg::queue_depth;

    // Word slots with their last flags
    qsys_types_pkg::data_t mem      [store_words];
    logic                  last_mem [store_words];

    qsys_types_pkg::q_ptr_t wr_ptr [qsys_cfg_pkg::num_queues];
    qsys_types_pkg::q_ptr_t rd_ptr [qsys_cfg_pkg::num_queues];

    // 0 to queue_depth words
    logic [$clog2(qsys_cfg_pkg::queue_depth):0] fill [qsys_cfg_pkg::num_queues];

    logic [qsys_cfg_pkg::num_queues-1:0] wr_sel;
    logic [qsys_cfg_pkg::num_queues-1:0] rd_sel;

    assign wr_sel = wr_en ? (qsys_cfg_pkg::num_queues'(1) << wr_queue) : '0;
    assign rd_sel = rd_en ? (qsys_cfg_pkg::num_queues'(1) << rd_queue) : '0;

    //////////////////////////////////////////////////////////////
    // Storage

    always_ff @(posedge core_clk_ifc) begin
        if (wr_en) begin
            mem[{wr_queue, wr_ptr[wr_queue]}]      <= wr_data;
            last_mem[{wr_queue, wr_ptr[wr_queue]}] <= wr_last;
        end
    end

    // Head of the queue being read
    assign head_data = mem[{rd_queue, rd_ptr[rd_queue]}];
    assign head_last = last_mem[{rd_queue, rd_ptr[rd_queue]}];

    //////////////////////////////////////////////////////////////
    // Pointers and fill counts

    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            for (int q = 0; q < qsys_cfg_pkg::num_queues; q++) begin
                wr_ptr[q] <= '0;
                rd_ptr[q] <= '0;
                fill[q]   <= '0;
            end
        end else begin
            for (int q = 0; q < qsys_cfg_pkg::num_queues; q++) begin
                if (wr_sel[q]) begin
                    wr_ptr[q] <= wr_ptr[q] + 1'b1;
                end
                if (rd_sel[q]) begin
                    rd_ptr[q] <= rd_ptr[q] + 1'b1;
                end
                // Simultaneous write and read leaves the fill unchanged
                case ({wr_sel[q], rd_sel[q]})
                    2'b10:   fill[q] <= fill[q] + 1'b1;
                    2'b01:   fill[q] <= fill[q] - 1'b1;
                    default: fill[q] <= fill[q];
                endcase
            end
        end
    end

    always_comb begin
        for (int q = 0; q < qsys_cfg_pkg::num_queues; q++) begin
            full[q] = (fill[q] == qsys_cfg_pkg::queue_depth);
        end
    end

    //////////////////////////////////////////////////////////////
    // Assertions

    // Top must hold back input words aimed at a full queue
    a_no_write_full: assert property (
        @(posedge core_clk_ifc) disable iff (!rst_n)
        wr_en |-> !full[wr_queue]
    );

    // Dequeue FSM only reads queues holding a stored packet
    a_no_read_empty: assert property (
        @(posedge core_clk_ifc) disable iff (!rst_n)
        rd_en |-> (fill[rd_queue] != '0)
    );

endmodule

// File: logic/packet_counts.sv
/* Count of whole packets waiting in each queue */

`timescale 1ns/1ps

module packet_counts (
    input  logic                                   core_clk_ifc,
    input  logic                                   rst_n,
    input  logic                                   pkt_in,
    input  qsys_types_pkg::queue_id_t              pkt_in_queue,
    input  logic                                   pkt_out,
    input  qsys_types_pkg::queue_id_t              pkt_out_queue,
    output logic [qsys_cfg_pkg::num_queues-1:0]    pkt_ready
);

    qsys_types_pkg::pkt_count_t counts [qsys_cfg_pkg::num_queues];

    logic [qsys_cfg_pkg::num_queues-1:0] in_sel;
    logic [qsys_cfg_pkg::num_queues-1:0] out_sel;

    assign in_sel  = pkt_in  ? (qsys_cfg_pkg::num_queues'(1) << pkt_in_queue)  : '0;
    assign out_sel = pkt_out ? (qsys_cfg_pkg::num_queues'(1) << pkt_out_queue) : '0;

    //////////////////////////////////////////////////////////////
    // Counters

    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            for (int q = 0; q < qsys_cfg_pkg::num_queues; q++) begin
                counts[q] <= '0;
            end
        end else begin
            for (int q = 0; q < qsys_cfg_pkg::num_queues; q++) begin
                // A packet may complete and leave the same queue in one cycle
                case ({in_sel[q], out_sel[q]})
                    2'b10:   counts[q] <= counts[q] + 1'b1;
                    2'b01:   counts[q] <= counts[q] - 1'b1;
                    default: counts[q] <= counts[q];
                endcase
            end
        end
    end

    always_comb begin
        for (int q = 0; q < qsys_cfg_pkg::num_queues; q++) begin
            pkt_ready[q] = (counts[q] != '0);
        end
    end

    //////////////////////////////////////////////////////////////
    // Assertions

    // Last word leaves only from a queue whose packet was fully stored
    a_no_underflow: assert property (
        @(posedge core_clk_ifc) disable iff (!rst_n)
        pkt_out |-> (counts[pkt_out_queue] != '0)
    );

endmodule

// File: logic/dequeue_fsm.sv
/* Round-robin port and strict-priority queue selection,
   word-by-word dequeue onto the registered output */

`timescale 1ns/1ps

module dequeue_fsm (
    input  logic                                   core_clk_ifc,
    input  logic                                   rst_n,
    input  logic [qsys_cfg_pkg::num_queues-1:0]    pkt_ready,
    input  qsys_types_pkg::port_mask_t             egr_buf_ready,
    input  qsys_types_pkg::data_t                  head_data,
    input  logic                                   head_last,
    output logic                                   rd_en,
    output qsys_types_pkg::queue_id_t              rd_queue,
    output logic                                   out_valid,
    output qsys_types_pkg::data_t                  out_data,
    output logic                                   out_last,
    output qsys_types_pkg::egr_port_t              out_egr_port
);

    qsys_types_pkg::deq_state_t state;

    // Last port served
    qsys_types_pkg::egr_port_t rr_ptr;

    qsys_types_pkg::queue_id_t  sel_queue;
    qsys_types_pkg::egr_port_t  sel_port;
    qsys_types_pkg::port_mask_t port_pending;
    qsys_types_pkg::egr_port_t  pick_cand;
    qsys_types_pkg::egr_port_t  pick_port;
    qsys_types_pkg::prio_t      pick_prio;
    logic                       pick_found;

    //////////////////////////////////////////////////////////////
    // Selection

    always_comb begin
        for (int p = 0; p < qsys_cfg_pkg::num_egr_ports; p++) begin
            port_pending[p] = |pkt_ready[p*qsys_cfg_pkg::num_prios +: qsys_cfg_pkg::num_prios];
        end
    end

    // Scan ports starting after rr_ptr, the served port comes last
    always_comb begin
        pick_port  = rr_ptr;
        pick_found = 1'b0;
        pick_cand  = rr_ptr;
        for (int i = 1; i <= qsys_cfg_pkg::num_egr_ports; i++) begin
            pick_cand = rr_ptr + qsys_types_pkg::egr_port_t'(i);
            if (!pick_found && port_pending[pick_cand]) begin
                pick_port  = pick_cand;
                pick_found = 1'b1;
            end
        end
        // High priority wins within the port
        pick_prio = pkt_ready[{pick_port, 1'b1}] ? 1'b1 : 1'b0;
    end

    assign sel_port = qsys_types_pkg::egr_port_t'(sel_queue >> 1);
    assign rd_queue = sel_queue;
    assign rd_en    = (state == qsys_types_pkg::send) && egr_buf_ready[sel_port];

    //////////////////////////////////////////////////////////////
    // State machine

    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            state     <= qsys_types_pkg::idle;
            rr_ptr    <= qsys_types_pkg::egr_port_t'(qsys_cfg_pkg::num_egr_ports - 1);
            sel_queue <= '0;
        end else begin
            case (state)
                qsys_types_pkg::idle: begin
                    if (|pkt_ready) begin
                        state <= qsys_types_pkg::pick;
                    end
                end
                qsys_types_pkg::pick: begin
                    if (pick_found) begin
                        sel_queue <= {pick_port, pick_prio};
                        rr_ptr    <= pick_port;
                        state     <= qsys_types_pkg::send;
                    end else begin
                        state <= qsys_types_pkg::idle;
                    end
                end
                qsys_types_pkg::send: begin
                    // Stay here while the port is stalled
                    if (rd_en && head_last) begin
                        state <= qsys_types_pkg::idle;
                    end
                end
                default: state <= qsys_types_pkg::idle;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////
    // Output register

    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            out_valid <= rd_en;
            out_last  <= rd_en && head_last;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (rd_en) begin
            out_data     <= head_data;
            out_egr_port <= sel_port;
        end
    end

    // Queue being sent keeps a whole packet counted until its last word leaves
    a_send_has_packet: assert property (
        @(posedge core_clk_ifc) disable iff (!rst_n)
        (state == qsys_types_pkg::send) |-> pkt_ready[sel_queue]
    );

endmodule

// File: logic/packet_queue_system.sv
/* Top of the packet queue system, joining the word store,
   the packet counters and the dequeue FSM */

`timescale 1ns/1ps

module packet_queue_system (
    input  logic                          core_clk_ifc,
    input  logic                          rst_n,
    input  logic                          in_valid,
    input  qsys_types_pkg::data_t         in_data,
    input  logic                          in_last,
    input  qsys_types_pkg::egr_port_t     in_egr_port,
    input  qsys_types_pkg::prio_t         in_prio,
    output logic                          in_ready,
    input  qsys_types_pkg::port_mask_t    egr_buf_ready,
    output logic                          out_valid,
    output qsys_types_pkg::data_t         out_data,
    output logic                          out_last,
    output qsys_types_pkg::egr_port_t     out_egr_port
);

    qsys_types_pkg::queue_id_t            wr_queue;
    qsys_types_pkg::queue_id_t            rd_queue;
    qsys_types_pkg::data_t                head_data;
    logic                                 head_last;
    logic [qsys_cfg_pkg::num_queues-1:0]  full;
    logic [qsys_cfg_pkg::num_queues-1:0]  pkt_ready;
    logic                                 wr_en;
    logic                                 rd_en;

    //////////////////////////////////////////////////////////////
    // Input side

    assign wr_queue = {in_egr_port, in_prio};

    // Only words for a full queue are held back
    assign in_ready = !full[wr_queue];
    assign wr_en    = in_valid && in_ready;

    queue_store u_queue_store (
        .core_clk_ifc ( core_clk_ifc ),
        .rst_n        ( rst_n        ),
        .wr_en        ( wr_en        ),
        .wr_queue     ( wr_queue     ),
        .wr_data      ( in_data      ),
        .wr_last      ( in_last      ),
        .rd_en        ( rd_en        ),
        .rd_queue     ( rd_queue     ),
        .head_data    ( head_data    ),
        .head_last    ( head_last    ),
        .full         ( full         )
    );

    packet_counts u_packet_counts (
        .core_clk_ifc  ( core_clk_ifc          ),
        .rst_n         ( rst_n                 ),
        .pkt_in        ( wr_en && in_last      ),
        .pkt_in_queue  ( wr_queue              ),
        .pkt_out       ( rd_en && head_last    ),
        .pkt_out_queue ( rd_queue              ),
        .pkt_ready     ( pkt_ready             )
    );

    dequeue_fsm u_dequeue_fsm (
        .core_clk_ifc  ( core_clk_ifc  ),
        .rst_n         ( rst_n         ),
        .pkt_ready     ( pkt_ready     ),
        .egr_buf_ready ( egr_buf_ready ),
        .head_data     ( head_data     ),
        .head_last     ( head_last     ),
        .rd_en         ( rd_en         ),
        .rd_queue      ( rd_queue      ),
        .out_valid     ( out_valid     ),
        .out_data      ( out_data      ),
        .out_last      ( out_last      ),
        .out_egr_port  ( out_egr_port  )
    );

endmodule

// File: include/qsys_stim_table.svh
/* Testbench stimulus table: fixed-phase packets, random-phase queues
   and the egress ready masks held while each phase enqueues */

`ifndef QSYS_STIM_TABLE_SVH
`define QSYS_STIM_TABLE_SVH

// Phases 0 single, 1 priority, 2 back-pressure, 3 random
localparam int stim_num_phases  = 4;
localparam int stim_num_fixed   = 6;
localparam int stim_num_random  = 40;
localparam int stim_num_entries = stim_num_fixed + stim_num_random;

// Ready drops this many cycles after each word in the random phase
localparam int stim_ready_drop_cycles = 8;

// Fixed packets, back-pressure fills 16 words then one more packet waits
localparam int                        stim_fixed_phase [stim_num_fixed] = '{0, 1, 1, 2, 2, 2};
localparam qsys_types_pkg::egr_port_t stim_fixed_port  [stim_num_fixed] = '{2, 1, 1, 3, 3, 3};
localparam qsys_types_pkg::prio_t     stim_fixed_prio  [stim_num_fixed] = '{0, 0, 1, 0, 0, 0};
localparam int                        stim_fixed_len   [stim_num_fixed] = '{5, 4, 3, 8, 8, 4};

// Ready mask held during each phase's enqueue, all ports released after
localparam qsys_types_pkg::port_mask_t stim_hold_ready [stim_num_phases] = '{
    4'b1111, 4'b1101, 4'b0111, 4'b1111
};

// Random phase queues, lengths come from the generator
localparam qsys_types_pkg::egr_port_t stim_rnd_port [stim_num_random] = '{
    0, 3, 1, 2, 2, 0, 1, 3, 0, 1, 2, 3, 3, 1, 0, 2, 1, 0, 3, 2,
    2, 1, 0, 3, 1, 2, 0, 0, 3, 1, 2, 3, 1, 0, 2, 3, 0, 1, 3, 2
};
localparam qsys_types_pkg::prio_t stim_rnd_prio [stim_num_random] = '{
    1, 0, 0, 1, 0, 1, 1, 0, 0, 0, 1, 1, 0, 1, 0, 0, 1, 0, 1, 0,
    0, 1, 1, 0, 0, 0, 1, 0, 1, 1, 0, 0, 1, 0, 1, 0, 0, 1, 1, 0
};

`endif

// File: verification/packet_queue_system_tb.sv
/* Testbench of the packet queue system: clock, reset, table-driven phases,
   per-queue scoreboard, compare tasks, egress ready pattern and watchdog */

`timescale 1ns/1ps

module packet_queue_system_tb;

    `include "qsys_stim_table.svh"

    localparam int watchdog_cycles = stim_num_entries * qsys_cfg_pkg::max_pkt_words * 12;

    logic                              core_clk_ifc;
    logic                              rst_n;
    logic                              in_valid;
    qsys_types_pkg::data_t             in_data;
    logic                              in_last;
    qsys_types_pkg::egr_port_t         in_egr_port;
    qsys_types_pkg::prio_t             in_prio;
    logic                              in_ready;
    qsys_types_pkg::port_mask_t        egr_buf_ready;
    logic                              out_valid;
    qsys_types_pkg::data_t             out_data;
    logic                              out_last;
    qsys_types_pkg::egr_port_t         out_egr_port;

    // Expected words per queue, in enqueue order
    qsys_types_pkg::data_t             exp_data [qsys_cfg_pkg::num_queues][$];
    logic                              exp_last [qsys_cfg_pkg::num_queues][$];
    int                                exp_pkts [qsys_cfg_pkg::num_egr_ports];
    int                                got_pkts [qsys_cfg_pkg::num_egr_ports];
    int                                drop_left [qsys_cfg_pkg::num_egr_ports];

    qsys_types_pkg::port_mask_t        hold_mask;
    qsys_types_pkg::port_mask_t        prev_ready;
    qsys_types_pkg::egr_port_t         cur_port;
    logic                              rnd_mode;
    logic                              in_pkt;
    int                                cur_q;
    int                                prio_check_port;
    int                                error_count;
    logic [31:0]                       lcg_state;

    packet_queue_system UUT (
        .core_clk_ifc  ( core_clk_ifc  ),
        .rst_n         ( rst_n         ),
        .in_valid      ( in_valid      ),
        .in_data       ( in_data       ),
        .in_last       ( in_last       ),
        .in_egr_port   ( in_egr_port   ),
        .in_prio       ( in_prio       ),
        .in_ready      ( in_ready      ),
        .egr_buf_ready ( egr_buf_ready ),
        .out_valid     ( out_valid     ),
        .out_data      ( out_data      ),
        .out_last      ( out_last      ),
        .out_egr_port  ( out_egr_port  )
    );

    initial begin
        core_clk_ifc = 1'b0;
        forever #2 core_clk_ifc = ~core_clk_ifc;
    end

    //////////////////////////////////////////////////////////////
    // Helpers

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic end_with_failure();
        error_count++;
        $display("Errors found");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic compare_data(input qsys_types_pkg::data_t got, input qsys_types_pkg::data_t exp,
                                input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
            end_with_failure();
        end
    endtask

    task automatic compare_port(input qsys_types_pkg::egr_port_t got,
                                input qsys_types_pkg::egr_port_t exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s got %0d expected %0d", $time, what, got, exp);
            end_with_failure();
        end
    endtask

    task automatic compare_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
            end_with_failure();
        end
    endtask

    task automatic compare_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("ERR %0t: %s got %0d expected %0d", $time, what, got, exp);
            end_with_failure();
        end
    endtask

    //////////////////////////////////////////////////////////////
    // Input side, called at 1 ns after a rising edge

    task automatic put_word(input qsys_types_pkg::data_t data, input logic last,
                            input qsys_types_pkg::egr_port_t port, input qsys_types_pkg::prio_t prio);
        int q;
        q = port * qsys_cfg_pkg::num_prios + prio;
        in_valid    = 1'b1;
        in_data     = data;
        in_last     = last;
        in_egr_port = port;
        in_prio     = prio;
        @(negedge core_clk_ifc);
        // Port held, so nothing has left the queue and its fill is the expected list size
        if (!rnd_mode && !hold_mask[port]) begin
            compare_flag(in_ready, exp_data[q].size() < qsys_cfg_pkg::queue_depth,
                         "in_ready with port held");
            if (!in_ready) begin
                hold_mask = '1;
            end
        end
        while (!in_ready) begin
            @(negedge core_clk_ifc);
        end
        exp_data[q].push_back(data);
        exp_last[q].push_back(last);
        @(posedge core_clk_ifc);
        #1;
        in_valid = 1'b0;
        in_last  = 1'b0;
    endtask

    task automatic put_packet(input qsys_types_pkg::egr_port_t port,
                              input qsys_types_pkg::prio_t prio, input int len);
        for (int i = 0; i < len; i++) begin
            put_word(lcg_next(), i == len - 1, port, prio);
        end
        exp_pkts[port]++;
    endtask

    // Low packet completes one cycle before the high one, both wait at the pick
    task automatic put_priority_pair();
        int lo_e;
        int hi_e;
        lo_e = 0;
        hi_e = 0;
        for (int e = 0; e < stim_num_fixed; e++) begin
            if (stim_fixed_phase[e] == 1 && stim_fixed_prio[e] == 1'b0) lo_e = e;
            if (stim_fixed_phase[e] == 1 && stim_fixed_prio[e] == 1'b1) hi_e = e;
        end
        prio_check_port = stim_fixed_port[hi_e];
        for (int i = 0; i < stim_fixed_len[lo_e] - 1; i++) begin
            put_word(lcg_next(), 1'b0, stim_fixed_port[lo_e], 1'b0);
        end
        for (int i = 0; i < stim_fixed_len[hi_e] - 1; i++) begin
            put_word(lcg_next(), 1'b0, stim_fixed_port[hi_e], 1'b1);
        end
        put_word(lcg_next(), 1'b1, stim_fixed_port[lo_e], 1'b0);
        put_word(lcg_next(), 1'b1, stim_fixed_port[hi_e], 1'b1);
        exp_pkts[stim_fixed_port[lo_e]]++;
        exp_pkts[stim_fixed_port[hi_e]]++;
    endtask

    task automatic wait_drained();
        int pending;
        do begin
            @(posedge core_clk_ifc);
            pending = 0;
            for (int q = 0; q < qsys_cfg_pkg::num_queues; q++) begin
                pending += exp_data[q].size();
            end
        end while (pending != 0 || in_pkt);
        #1;
    endtask

    //////////////////////////////////////////////////////////////
    // Egress ready and output monitor

    initial begin
        egr_buf_ready = '1;
        forever begin
            @(posedge core_clk_ifc);
            #1;
            for (int p = 0; p < qsys_cfg_pkg::num_egr_ports; p++) begin
                if (rnd_mode) begin
                    egr_buf_ready[p] = (drop_left[p] == 0);
                    if (drop_left[p] > 0) drop_left[p]--;
                end else begin
                    egr_buf_ready[p] = hold_mask[p];
                end
            end
        end
    end

    task automatic check_output_word();
        int hi_q;
        int lo_q;
        if (!prev_ready[out_egr_port]) begin
            $display("%0t: word on port %0d whose ready was low the cycle before",
                     $time, out_egr_port);
            end_with_failure();
        end
        if (!in_pkt) begin
            hi_q     = out_egr_port * qsys_cfg_pkg::num_prios + 1;
            lo_q     = out_egr_port * qsys_cfg_pkg::num_prios;
            cur_port = out_egr_port;
            if (exp_data[hi_q].size() != 0 && exp_data[hi_q][0] === out_data) begin
                cur_q = hi_q;
            end else if (exp_data[lo_q].size() != 0 && exp_data[lo_q][0] === out_data) begin
                cur_q = lo_q;
            end else begin
                $display("%0t: output word %h on port %0d starts no stored packet",
                         $time, out_data, out_egr_port);
                end_with_failure();
            end
            if (prio_check_port == cur_port) begin
                compare_flag(cur_q[0], 1'b1, "priority of first packet after release");
                prio_check_port = -1;
            end
        end
        if (exp_data[cur_q].size() == 0) begin
            $display("%0t: more words on port %0d than were stored", $time, out_egr_port);
            end_with_failure();
        end
        compare_port(out_egr_port, cur_port, "out_egr_port within packet");
        compare_data(out_data, exp_data[cur_q].pop_front(), "out_data");
        compare_flag(out_last, exp_last[cur_q].pop_front(), "out_last");
        if (out_last) got_pkts[cur_port]++;
        in_pkt = !out_last;
        if (rnd_mode) drop_left[out_egr_port] = stim_ready_drop_cycles;
    endtask

    initial begin
        forever begin
            @(negedge core_clk_ifc);
            if (rst_n && out_valid) check_output_word();
            prev_ready = egr_buf_ready;
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge core_clk_ifc);
        $display("Timeout: the run did not finish within %0d clock cycles", watchdog_cycles);
        end_with_failure();
    end

    //////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        rst_n           = 1'b0;
        in_valid        = 1'b0;
        in_data         = '0;
        in_last         = 1'b0;
        in_egr_port     = '0;
        in_prio         = '0;
        hold_mask       = '1;
        rnd_mode        = 1'b0;
        in_pkt          = 1'b0;
        prio_check_port = -1;
        error_count     = 0;
        lcg_state       = 32'd3316;
        @(negedge core_clk_ifc);
        compare_flag(out_valid, 1'b0, "out_valid in reset");
        compare_flag(in_ready, 1'b1, "in_ready in reset");
        @(posedge core_clk_ifc);
        #1;
        rst_n = 1'b1;
        @(negedge core_clk_ifc);
        compare_flag(out_valid, 1'b0, "out_valid after reset");
        compare_flag(in_ready, 1'b1, "in_ready after reset");
        @(posedge core_clk_ifc);
        #1;

        // Single, priority and back-pressure phases
        for (int ph = 0; ph < stim_num_phases - 1; ph++) begin
            hold_mask = stim_hold_ready[ph];
            if (ph == 1) begin
                put_priority_pair();
            end else begin
                for (int e = 0; e < stim_num_fixed; e++) begin
                    if (stim_fixed_phase[e] == ph) begin
                        put_packet(stim_fixed_port[e], stim_fixed_prio[e], stim_fixed_len[e]);
                    end
                end
            end
            hold_mask = '1;
            wait_drained();
        end

        // Random traffic with the dropping ready pattern
        hold_mask = stim_hold_ready[stim_num_phases-1];
        rnd_mode  = 1'b1;
        for (int i = 0; i < stim_num_random; i++) begin
            put_packet(stim_rnd_port[i], stim_rnd_prio[i],
                       1 + ((lcg_next() >> 8) % qsys_cfg_pkg::max_pkt_words));
        end
        wait_drained();
        rnd_mode = 1'b0;

        for (int p = 0; p < qsys_cfg_pkg::num_egr_ports; p++) begin
            compare_count(got_pkts[p], exp_pkts[p], "packets out on port");
        end

        if (error_count == 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("Errors found");
            $fatal(1, "Run ended with mismatches");
        end
    end

endmodule

// File: flist.f
+incdir+include
logic/qsys_cfg_pkg.sv
logic/qsys_types_pkg.sv
logic/queue_store.sv
logic/packet_counts.sv
logic/dequeue_fsm.sv
logic/packet_queue_system.sv
verification/packet_queue_system_tb.sv
